// File: common/mmu_defines.svh
`ifndef MMU_DEFINES_SVH
`define MMU_DEFINES_SVH

// table geometry
`define TLBNUM   16
`define TLBIDLEN 4

`define VALEN 32
`define PALEN 32

// page size codes held in an entry
`define PS_SMALL 6'd12
`define PS_LARGE 6'd21

`endif

// File: common/mmu_pkg.sv
`include "mmu_defines.svh"

package mmu_pkg;

    // even half uses the 0 fields, odd half the 1 fields
    typedef struct packed {
        logic        e;
        logic [18:0] vppn;
        logic [5:0]  ps;
        logic [9:0]  asid;
        logic        g;
        logic [19:0] ppn0;
        logic [1:0]  plv0;
        logic [1:0]  mat0;
        logic        d0;
        logic        v0;
        logic [19:0] ppn1;
        logic [1:0]  plv1;
        logic [1:0]  mat1;
        logic        d1;
        logic        v1;
    } tlb_entry_t;

    typedef struct packed {
        logic                 found;
        logic [`TLBIDLEN-1:0] index;
        logic [19:0]          ppn;
        logic [5:0]           ps;
        logic [1:0]           plv;
        logic [1:0]           mat;
        logic                 d;
        logic                 v;
    } tlb_result_t;

    typedef enum logic [2:0] {
        OP_SRCH,
        OP_RD,
        OP_WR,
        OP_FILL,
        OP_INV
    } tlb_op_e;

    // encodings follow the invtlb op field
    typedef enum logic [4:0] {
        INV_ALL0       = 5'h0,
        INV_ALL1       = 5'h1,
        INV_G1         = 5'h2,
        INV_G0         = 5'h3,
        INV_G0_ASID    = 5'h4,
        INV_G0_ASID_VA = 5'h5,
        INV_G1_ASID_VA = 5'h6
    } inv_op_e;

    typedef enum logic [1:0] {
        ACC_FETCH,
        ACC_LOAD,
        ACC_STORE
    } access_e;

    typedef enum logic [2:0] {
        EXC_NONE,
        EXC_TLBR,
        EXC_PIF,
        EXC_PIL,
        EXC_PIS,
        EXC_PPI,
        EXC_PME
    } exc_code_e;

endpackage

// File: common/tlb_mgmt_if.sv
`timescale 1ns/10ps
`include "mmu_defines.svh"

interface tlb_mgmt_if;

    logic                 we;
    logic [`TLBIDLEN-1:0] w_index;
    mmu_pkg::tlb_entry_t  w_entry;
    logic [`TLBIDLEN-1:0] r_index;
    mmu_pkg::tlb_entry_t  r_entry;
    logic                 invtlb_valid;
    mmu_pkg::inv_op_e     invtlb_op;
    logic [9:0]           invtlb_asid;
    logic [`VALEN-1:0]    invtlb_va;

    modport ctrl (
        output we, w_index, w_entry,
        output r_index,
        input  r_entry,
        output invtlb_valid, invtlb_op, invtlb_asid, invtlb_va
    );

    modport tlb (
        input  we, w_index, w_entry,
        input  r_index,
        output r_entry,
        input  invtlb_valid, invtlb_op, invtlb_asid, invtlb_va
    );

endinterface

// File: common/tlb_search_if.sv
`timescale 1ns/10ps

interface tlb_search_if;

    logic [18:0]          vppn;
    logic                 va_bit12;
    logic [9:0]           asid;
    mmu_pkg::tlb_result_t result;

    // result comes back in the same cycle
    modport requester (
        output vppn,
        output va_bit12,
        output asid,
        input  result
    );

    modport tlb (
        input  vppn,
        input  va_bit12,
        input  asid,
        output result
    );

endinterface

// File: design/addr_translate.sv
`timescale 1ns/10ps
`include "mmu_defines.svh"

module addr_translate (
    input  logic [`VALEN-1:0]   va,
    input  mmu_pkg::access_e    acc,
    input  logic [1:0]          cur_plv,
    input  logic [9:0]          cur_asid,
    tlb_search_if.requester     s,
    output logic [`PALEN-1:0]   pa,
    output mmu_pkg::exc_code_e  exc
);

    logic [`PALEN-1:0] phys;

    assign s.vppn = va[`VALEN-1:13];
    assign s.va_bit12 = va[12];
    assign s.asid = cur_asid;

    // offset width follows the page size
    always_comb begin
        if (s.result.ps == `PS_LARGE)
            phys = {s.result.ppn[19:9], va[20:0]};
        else
            phys = {s.result.ppn, va[11:0]};
    end

    // refill, invalid, privilege, modify
    always_comb begin
        if (!s.result.found) begin
            exc = mmu_pkg::EXC_TLBR;
        end else if (!s.result.v) begin
            case (acc)
                mmu_pkg::ACC_FETCH: exc = mmu_pkg::EXC_PIF;
                mmu_pkg::ACC_LOAD:  exc = mmu_pkg::EXC_PIL;
                default:            exc = mmu_pkg::EXC_PIS;
            endcase
        end else if (cur_plv > s.result.plv) begin
            exc = mmu_pkg::EXC_PPI;
        end else if (acc == mmu_pkg::ACC_STORE && !s.result.d) begin
            exc = mmu_pkg::EXC_PME;
        end else begin
            exc = mmu_pkg::EXC_NONE;
        end
    end

    assign pa = (exc == mmu_pkg::EXC_NONE) ? phys : '0;

endmodule

// File: design/mmu_top.sv
`timescale 1ns/10ps
`include "mmu_defines.svh"

module mmu_top (
    input  logic                 clk,
    input  logic                 reset,

    input  logic [`VALEN-1:0]    fetch_va,
    output logic [`PALEN-1:0]    fetch_pa,
    output mmu_pkg::exc_code_e   fetch_exc,

    input  logic [`VALEN-1:0]    data_va,
    input  logic                 data_store,
    output logic [`PALEN-1:0]    data_pa,
    output mmu_pkg::exc_code_e   data_exc,

    input  logic [1:0]           cur_plv,
    input  logic [9:0]           cur_asid,

    input  logic                 op_valid,
    input  mmu_pkg::tlb_op_e     op,
    input  logic [`TLBIDLEN-1:0] op_index,
    input  mmu_pkg::tlb_entry_t  op_entry,
    input  mmu_pkg::inv_op_e     inv_op,
    input  logic [`VALEN-1:0]    op_va,
    output logic                 op_done,
    output logic                 srch_hit,
    output logic [`TLBIDLEN-1:0] srch_index,
    output mmu_pkg::tlb_entry_t  rd_entry
);

    mmu_pkg::access_e data_acc;

    tlb_search_if s_fetch_if ();
    tlb_search_if s_data_if ();
    tlb_search_if s_ctrl_if ();
    tlb_mgmt_if   mgmt_if ();

    assign data_acc = data_store ? mmu_pkg::ACC_STORE : mmu_pkg::ACC_LOAD;

    tlb u_tlb (
        .clk     (clk),
        .reset   (reset),
        .s_fetch (s_fetch_if.tlb),
        .s_data  (s_data_if.tlb),
        .s_ctrl  (s_ctrl_if.tlb),
        .mgmt    (mgmt_if.tlb)
    );

    addr_translate u_fetch_xlat (
        .va       (fetch_va),
        .acc      (mmu_pkg::ACC_FETCH),
        .cur_plv  (cur_plv),
        .cur_asid (cur_asid),
        .s        (s_fetch_if.requester),
        .pa       (fetch_pa),
        .exc      (fetch_exc)
    );

    addr_translate u_data_xlat (
        .va       (data_va),
        .acc      (data_acc),
        .cur_plv  (cur_plv),
        .cur_asid (cur_asid),
        .s        (s_data_if.requester),
        .pa       (data_pa),
        .exc      (data_exc)
    );

    tlb_ctrl u_ctrl (
        .clk        (clk),
        .reset      (reset),
        .op_valid   (op_valid),
        .op         (op),
        .op_index   (op_index),
        .op_entry   (op_entry),
        .inv_op     (inv_op),
        .op_va      (op_va),
        .cur_asid   (cur_asid),
        .s          (s_ctrl_if.requester),
        .mgmt       (mgmt_if.ctrl),
        .op_done    (op_done),
        .srch_hit   (srch_hit),
        .srch_index (srch_index),
        .rd_entry   (rd_entry)
    );

endmodule

// File: design/tlb_ctrl.sv
`timescale 1ns/10ps
`include "mmu_defines.svh"

module tlb_ctrl (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 op_valid,
    input  mmu_pkg::tlb_op_e     op,
    input  logic [`TLBIDLEN-1:0] op_index,
    input  mmu_pkg::tlb_entry_t  op_entry,
    input  mmu_pkg::inv_op_e     inv_op,
    input  logic [`VALEN-1:0]    op_va,
    input  logic [9:0]           cur_asid,
    tlb_search_if.requester      s,
    tlb_mgmt_if.ctrl             mgmt,
    output logic                 op_done,
    output logic                 srch_hit,
    output logic [`TLBIDLEN-1:0] srch_index,
    output mmu_pkg::tlb_entry_t  rd_entry
);

    logic                 do_srch;
    logic                 do_rd;
    logic                 do_wr;
    logic                 do_fill;
    logic                 do_inv;
    logic [`TLBIDLEN-1:0] lfsr;

    assign do_srch = op_valid && op == mmu_pkg::OP_SRCH;
    assign do_rd = op_valid && op == mmu_pkg::OP_RD;
    assign do_wr = op_valid && op == mmu_pkg::OP_WR;
    assign do_fill = op_valid && op == mmu_pkg::OP_FILL;
    assign do_inv = op_valid && op == mmu_pkg::OP_INV;

    // x^4 + x^3 + 1 taps keep the state off zero
    always_ff @(posedge clk) begin
        if (reset)
            lfsr <= 4'b1000;
        else
            lfsr <= {lfsr[2:0], lfsr[3] ^ lfsr[2]};
    end

    assign mgmt.we = do_wr || do_fill;
    assign mgmt.w_index = do_fill ? lfsr : op_index;
    assign mgmt.w_entry = op_entry;
    assign mgmt.r_index = op_index;

    assign mgmt.invtlb_valid = do_inv;
    assign mgmt.invtlb_op = inv_op;
    assign mgmt.invtlb_asid = cur_asid;
    assign mgmt.invtlb_va = op_va;

    // search key taken from op_va and the current asid
    assign s.vppn = op_va[`VALEN-1:13];
    assign s.va_bit12 = op_va[12];
    assign s.asid = cur_asid;

    always_ff @(posedge clk) begin
        if (reset) begin
            op_done <= 1'b0;
            srch_hit <= 1'b0;
            srch_index <= '0;
        end else begin
            op_done <= op_valid;
            if (do_srch) begin
                srch_hit <= s.result.found;
                srch_index <= s.result.index;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_rd)
            rd_entry <= mgmt.r_entry;
    end

    a_inv_op_known: assert property (@(posedge clk) disable iff (reset)
        mgmt.invtlb_valid |-> inv_op inside {mmu_pkg::INV_ALL0, mmu_pkg::INV_ALL1,
                                             mmu_pkg::INV_G1, mmu_pkg::INV_G0,
                                             mmu_pkg::INV_G0_ASID, mmu_pkg::INV_G0_ASID_VA,
                                             mmu_pkg::INV_G1_ASID_VA});

endmodule

// File: mmu.f
+incdir+common
common/mmu_pkg.sv
common/tlb_search_if.sv
common/tlb_mgmt_if.sv
tlb/tlb.sv
design/addr_translate.sv
design/tlb_ctrl.sv
design/mmu_top.sv
verification/mmu_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the mmu testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module mmu_tb -f mmu.f -o mmu_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/mmu_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qF '*** PASSED ***'; then
    exit 0
fi
exit 1

// File: tlb/tlb.sv
`timescale 1ns/10ps
`include "mmu_defines.svh"

module tlb (
    input logic         clk,
    input logic         reset,
    tlb_search_if.tlb   s_fetch,
    tlb_search_if.tlb   s_data,
    tlb_search_if.tlb   s_ctrl,
    tlb_mgmt_if.tlb     mgmt
);

    logic [`TLBNUM-1:0]  tlb_e;
    mmu_pkg::tlb_entry_t tlb_ent [`TLBNUM];

    logic [`TLBNUM-1:0] hit_fetch;
    logic [`TLBNUM-1:0] hit_data;
    logic [`TLBNUM-1:0] hit_ctrl;
    logic [`TLBNUM-1:0] inv_hit;
    logic [18:0]        inv_vppn;

    // large pages only compare va[31:22]
    function automatic logic page_hit(input mmu_pkg::tlb_entry_t ent, input logic [18:0] vppn);
        if (ent.ps == `PS_LARGE)
            return ent.vppn[18:9] == vppn[18:9];
        return ent.vppn == vppn;
    endfunction

    function automatic logic [`TLBNUM-1:0] match_vec(input logic [18:0] vppn,
                                                     input logic [9:0] asid);
        logic [`TLBNUM-1:0] hit;
        for (int i = 0; i < `TLBNUM; i++) begin
            hit[i] = tlb_e[i] && page_hit(tlb_ent[i], vppn)
                     && (tlb_ent[i].g || tlb_ent[i].asid == asid);
        end
        return hit;
    endfunction

    function automatic mmu_pkg::tlb_result_t pick(input logic [`TLBNUM-1:0] hit,
                                                  input logic [18:0] vppn,
                                                  input logic va_bit12);
        mmu_pkg::tlb_result_t res;
        logic                 odd;
        res = '0;
        for (int i = 0; i < `TLBNUM; i++) begin
            if (hit[i]) begin
                // half select by va[12] for 4 KB and va[21] for large pages
                odd = (tlb_ent[i].ps == `PS_LARGE) ? vppn[8] : va_bit12;
                res.found = 1'b1;
                res.index = i[`TLBIDLEN-1:0];
                res.ps = tlb_ent[i].ps;
                res.ppn = odd ? tlb_ent[i].ppn1 : tlb_ent[i].ppn0;
                res.plv = odd ? tlb_ent[i].plv1 : tlb_ent[i].plv0;
                res.mat = odd ? tlb_ent[i].mat1 : tlb_ent[i].mat0;
                res.d = odd ? tlb_ent[i].d1 : tlb_ent[i].d0;
                res.v = odd ? tlb_ent[i].v1 : tlb_ent[i].v0;
            end
        end
        return res;
    endfunction

    always_comb begin
        hit_fetch = match_vec(s_fetch.vppn, s_fetch.asid);
        s_fetch.result = pick(hit_fetch, s_fetch.vppn, s_fetch.va_bit12);
    end

    always_comb begin
        hit_data = match_vec(s_data.vppn, s_data.asid);
        s_data.result = pick(hit_data, s_data.vppn, s_data.va_bit12);
    end

    always_comb begin
        hit_ctrl = match_vec(s_ctrl.vppn, s_ctrl.asid);
        s_ctrl.result = pick(hit_ctrl, s_ctrl.vppn, s_ctrl.va_bit12);
    end

    assign inv_vppn = mgmt.invtlb_va[`VALEN-1:13];

    // entries selected by the invalidate mode
    always_comb begin
        for (int i = 0; i < `TLBNUM; i++) begin
            case (mgmt.invtlb_op)
                mmu_pkg::INV_ALL0,
                mmu_pkg::INV_ALL1:
                    inv_hit[i] = 1'b1;
                mmu_pkg::INV_G1:
                    inv_hit[i] = tlb_ent[i].g;
                mmu_pkg::INV_G0:
                    inv_hit[i] = !tlb_ent[i].g;
                mmu_pkg::INV_G0_ASID:
                    inv_hit[i] = !tlb_ent[i].g && tlb_ent[i].asid == mgmt.invtlb_asid;
                mmu_pkg::INV_G0_ASID_VA:
                    inv_hit[i] = !tlb_ent[i].g && tlb_ent[i].asid == mgmt.invtlb_asid
                                 && page_hit(tlb_ent[i], inv_vppn);
                mmu_pkg::INV_G1_ASID_VA:
                    inv_hit[i] = (tlb_ent[i].g || tlb_ent[i].asid == mgmt.invtlb_asid)
                                 && page_hit(tlb_ent[i], inv_vppn);
                default:
                    inv_hit[i] = 1'b0;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            tlb_e <= '0;
        end else if (mgmt.we) begin
            tlb_e[mgmt.w_index] <= mgmt.w_entry.e;
        end else if (mgmt.invtlb_valid) begin
            tlb_e <= tlb_e & ~inv_hit;
        end
    end

    always_ff @(posedge clk) begin
        if (mgmt.we)
            tlb_ent[mgmt.w_index] <= mgmt.w_entry;
    end

    // e comes from the reset-cleared vector
    always_comb begin
        mgmt.r_entry = tlb_ent[mgmt.r_index];
        mgmt.r_entry.e = tlb_e[mgmt.r_index];
    end

    a_single_match: assert property (@(posedge clk) disable iff (reset)
        $onehot0(hit_fetch) && $onehot0(hit_data) && $onehot0(hit_ctrl));

    a_wr_inv_excl: assert property (@(posedge clk) disable iff (reset)
        !(mgmt.we && mgmt.invtlb_valid));

endmodule

// File: verification/mmu_tb.sv
`timescale 1ns/10ps
`include "mmu_defines.svh"

module mmu_tb;

    logic                 clk;
    logic                 reset;
    logic [`VALEN-1:0]    fetch_va;
    logic [`PALEN-1:0]    fetch_pa;
    mmu_pkg::exc_code_e   fetch_exc;
    logic [`VALEN-1:0]    data_va;
    logic                 data_store;
    logic [`PALEN-1:0]    data_pa;
    mmu_pkg::exc_code_e   data_exc;
    logic [1:0]           cur_plv;
    logic [9:0]           cur_asid;
    logic                 op_valid;
    mmu_pkg::tlb_op_e     op;
    logic [`TLBIDLEN-1:0] op_index;
    mmu_pkg::tlb_entry_t  op_entry;
    mmu_pkg::inv_op_e     inv_op;
    logic [`VALEN-1:0]    op_va;
    logic                 op_done;
    logic                 srch_hit;
    logic [`TLBIDLEN-1:0] srch_index;
    mmu_pkg::tlb_entry_t  rd_entry;

    int          errors;
    int          timeouts;

    mmu_top dut (.*);

    always #20 clk = ~clk;

    task automatic check_pa(input logic [`PALEN-1:0] got, input logic [`PALEN-1:0] exp,
                            input string what);
        if (got !== exp) begin
            errors++;
            $display("Error at %0t: %s pa %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_exc(input mmu_pkg::exc_code_e got, input mmu_pkg::exc_code_e exp,
                             input string what);
        if (got !== exp) begin
            errors++;
            $display("Error at %0t: %s exc %s, expected %s", $time, what, got.name(),
                     exp.name());
        end
    endtask

    task automatic check_entry(input mmu_pkg::tlb_entry_t got, input mmu_pkg::tlb_entry_t exp,
                               input string what);
        if (got !== exp) begin
            errors++;
            $display("Error at %0t: %s entry %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_index(input logic [`TLBIDLEN-1:0] got,
                               input logic [`TLBIDLEN-1:0] exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("Error at %0t: %s index %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("Error at %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    // all fields valid, dirty and user accessible unless a test changes them
    function automatic mmu_pkg::tlb_entry_t make_entry(input logic [18:0] vppn,
                                                       input logic [5:0] ps,
                                                       input logic [9:0] asid,
                                                       input logic g);
        mmu_pkg::tlb_entry_t ent;
        ent = '0;
        ent.e = 1'b1;
        ent.vppn = vppn;
        ent.ps = ps;
        ent.asid = asid;
        ent.g = g;
        ent.ppn0 = 20'($urandom);
        ent.ppn1 = 20'($urandom);
        ent.plv0 = 2'd3;
        ent.plv1 = 2'd3;
        ent.mat0 = 2'd1;
        ent.mat1 = 2'd1;
        ent.d0 = 1'b1;
        ent.d1 = 1'b1;
        ent.v0 = 1'b1;
        ent.v1 = 1'b1;
        return ent;
    endfunction

    // op_done is expected one cycle after the op is taken
    task automatic run_op(input mmu_pkg::tlb_op_e code, input logic [`TLBIDLEN-1:0] idx,
                          input mmu_pkg::tlb_entry_t ent, input mmu_pkg::inv_op_e mode,
                          input logic [`VALEN-1:0] va);
        int n;
        @(posedge clk);
        #2;
        op_valid = 1'b1;
        op = code;
        op_index = idx;
        op_entry = ent;
        inv_op = mode;
        op_va = va;
        @(posedge clk);
        #2;
        op_valid = 1'b0;
        n = 0;
        while (op_done !== 1'b1 && n < 10) begin
            @(posedge clk);
            #2;
            n++;
        end
        if (op_done !== 1'b1) begin
            timeouts++;
            $display("timeout: op_done never rose for %s at %0t", code.name(), $time);
        end
    endtask

    task automatic write_entry(input logic [`TLBIDLEN-1:0] idx, input mmu_pkg::tlb_entry_t ent);
        run_op(mmu_pkg::OP_WR, idx, ent, mmu_pkg::INV_ALL0, '0);
    endtask

    task automatic read_entry(input logic [`TLBIDLEN-1:0] idx);
        run_op(mmu_pkg::OP_RD, idx, '0, mmu_pkg::INV_ALL0, '0);
    endtask

    task automatic search_va(input logic [`VALEN-1:0] va);
        run_op(mmu_pkg::OP_SRCH, '0, '0, mmu_pkg::INV_ALL0, va);
    endtask

    task automatic invalidate(input mmu_pkg::inv_op_e mode, input logic [`VALEN-1:0] va);
        run_op(mmu_pkg::OP_INV, '0, '0, mode, va);
    endtask

    task automatic set_context(input logic [1:0] plv, input logic [9:0] asid);
        @(posedge clk);
        #2;
        cur_plv = plv;
        cur_asid = asid;
    endtask

    task automatic translate(input logic [`VALEN-1:0] fva, input logic [`VALEN-1:0] dva,
                             input logic store);
        @(posedge clk);
        #2;
        fetch_va = fva;
        data_va = dva;
        data_store = store;
        #10;
    endtask

    task automatic test_reset_state();
        check_flag(op_done, 1'b0, "op_done after reset");
        check_flag(srch_hit, 1'b0, "srch_hit after reset");
        for (int i = 0; i < `TLBNUM; i++) begin
            read_entry(4'(i));
            check_flag(rd_entry.e, 1'b0, $sformatf("e of entry %0d after reset", i));
        end
        translate({4'h1, 28'($urandom)}, '0, 1'b0);
        check_exc(fetch_exc, mmu_pkg::EXC_TLBR, "fetch on empty table");
    endtask

    task automatic test_write_read();
        mmu_pkg::tlb_entry_t ent;
        ent = make_entry({4'h1, 15'($urandom)}, `PS_SMALL, 10'($urandom), 1'b0);
        write_entry(4'd3, ent);
        read_entry(4'd3);
        check_entry(rd_entry, ent, "read back index 3");
        ent = make_entry({4'h2, 15'($urandom)}, `PS_LARGE, 10'($urandom), 1'b1);
        write_entry(4'd12, ent);
        read_entry(4'd12);
        check_entry(rd_entry, ent, "read back index 12");
    endtask

    task automatic test_translate();
        mmu_pkg::tlb_entry_t ent;
        logic [`VALEN-1:0]   va;
        logic [`VALEN-1:0]   dva;
        logic [9:0]          asid;
        asid = cur_asid;
        invalidate(mmu_pkg::INV_ALL0, '0);
        ent = make_entry({4'h1, 15'($urandom)}, `PS_SMALL, asid, 1'b0);
        write_entry(4'd5, ent);
        va = {ent.vppn, 1'b0, 12'($urandom)};
        dva = {ent.vppn, 1'b1, va[11:0]};
        translate(va, dva, 1'b0);
        check_exc(fetch_exc, mmu_pkg::EXC_NONE, "4k even fetch");
        check_pa(fetch_pa, {ent.ppn0, va[11:0]}, "4k even fetch");
        check_exc(data_exc, mmu_pkg::EXC_NONE, "4k odd load");
        check_pa(data_pa, {ent.ppn1, va[11:0]}, "4k odd load");
        set_context(cur_plv, asid ^ 10'h1);
        translate(va, dva, 1'b0);
        check_exc(fetch_exc, mmu_pkg::EXC_TLBR, "other asid, non-global");
        ent.g = 1'b1;
        write_entry(4'd5, ent);
        translate(va, dva, 1'b0);
        check_exc(fetch_exc, mmu_pkg::EXC_NONE, "other asid, global");
        check_pa(fetch_pa, {ent.ppn0, va[11:0]}, "other asid, global");
        set_context(cur_plv, asid);
        // large page whose va differs from the entry below vppn bit 9
        ent = make_entry({4'h2, 15'($urandom)}, `PS_LARGE, asid, 1'b0);
        write_entry(4'd6, ent);
        va = {ent.vppn[18:9], 1'b0, ~ent.vppn[7:0], 13'($urandom)};
        dva = {ent.vppn[18:9], 1'b1, ~ent.vppn[7:0], 13'($urandom)};
        translate(va, dva, 1'b0);
        check_exc(fetch_exc, mmu_pkg::EXC_NONE, "large even fetch");
        check_pa(fetch_pa, {ent.ppn0[19:9], va[20:0]}, "large even fetch");
        check_exc(data_exc, mmu_pkg::EXC_NONE, "large odd load");
        check_pa(data_pa, {ent.ppn1[19:9], dva[20:0]}, "large odd load");
    endtask

    task automatic test_exceptions();
        mmu_pkg::tlb_entry_t ent;
        logic [`VALEN-1:0]   even;
        logic [`VALEN-1:0]   odd;
        invalidate(mmu_pkg::INV_ALL0, '0);
        set_context(2'd0, cur_asid);
        ent = make_entry({4'h3, 15'($urandom)}, `PS_SMALL, cur_asid, 1'b0);
        ent.v0 = 1'b0;
        ent.plv1 = 2'd0;
        ent.d1 = 1'b0;
        write_entry(4'd7, ent);
        even = {ent.vppn, 1'b0, 12'($urandom)};
        odd = {ent.vppn, 1'b1, even[11:0]};
        translate(even, even, 1'b0);
        check_exc(fetch_exc, mmu_pkg::EXC_PIF, "invalid fetch");
        check_pa(fetch_pa, '0, "invalid fetch");
        check_exc(data_exc, mmu_pkg::EXC_PIL, "invalid load");
        translate(odd, even, 1'b1);
        check_exc(data_exc, mmu_pkg::EXC_PIS, "invalid store");
        check_exc(fetch_exc, mmu_pkg::EXC_NONE, "fetch of plv0 page at plv0");
        check_pa(fetch_pa, {ent.ppn1, odd[11:0]}, "fetch of plv0 page at plv0");
        translate(odd, odd, 1'b0);
        check_exc(data_exc, mmu_pkg::EXC_NONE, "load of clean page");
        check_pa(data_pa, {ent.ppn1, odd[11:0]}, "load of clean page");
        translate(odd, odd, 1'b1);
        check_exc(data_exc, mmu_pkg::EXC_PME, "store to clean page");
        check_pa(data_pa, '0, "store to clean page");
        // privilege ranks above modify
        set_context(2'd3, cur_asid);
        translate(odd, odd, 1'b1);
        check_exc(fetch_exc, mmu_pkg::EXC_PPI, "fetch at plv3");
        check_exc(data_exc, mmu_pkg::EXC_PPI, "store at plv3");
        set_context(2'd0, cur_asid);
    endtask

    task automatic test_search();
        mmu_pkg::tlb_entry_t ent;
        invalidate(mmu_pkg::INV_ALL0, '0);
        ent = make_entry({4'h4, 15'($urandom)}, `PS_SMALL, cur_asid, 1'b0);
        write_entry(4'd9, ent);
        search_va({ent.vppn, 13'($urandom)});
        check_flag(srch_hit, 1'b1, "search hit");
        check_index(srch_index, 4'd9, "search hit");
        search_va({4'h7, 28'($urandom)});
        check_flag(srch_hit, 1'b0, "search miss");
    endtask

    task automatic test_fill();
        mmu_pkg::tlb_entry_t  ent;
        logic [`TLBIDLEN-1:0] idx;
        invalidate(mmu_pkg::INV_ALL0, '0);
        ent = make_entry({4'h5, 15'($urandom)}, `PS_SMALL, cur_asid, 1'b0);
        run_op(mmu_pkg::OP_FILL, '0, ent, mmu_pkg::INV_ALL0, '0);
        search_va({ent.vppn, 13'($urandom)});
        check_flag(srch_hit, 1'b1, "search after fill");
        idx = srch_index;
        read_entry(idx);
        check_entry(rd_entry, ent, "read at fill index");
    endtask

    // entries 0 and 1 share page P, 2 is global on Q, 3 is on R and 4 is global on S
    task automatic test_invalidate();
        mmu_pkg::tlb_entry_t tab [5];
        mmu_pkg::inv_op_e    modes [7];
        logic [4:0]          keep [7];
        logic [18:0]         p;
        logic [`VALEN-1:0]   p_va;
        logic [`VALEN-1:0]   q_va;
        fetch_va = '0;
        data_va = '0;
        p = {4'h3, 15'($urandom)};
        tab[0] = make_entry(p, `PS_SMALL, cur_asid, 1'b0);
        tab[1] = make_entry(p, `PS_SMALL, ~cur_asid, 1'b0);
        tab[2] = make_entry({4'h4, 15'($urandom)}, `PS_SMALL, cur_asid, 1'b1);
        tab[3] = make_entry({4'h5, 15'($urandom)}, `PS_SMALL, cur_asid, 1'b0);
        tab[4] = make_entry({4'h6, 15'($urandom)}, `PS_SMALL, ~cur_asid, 1'b1);
        p_va = {p, 13'($urandom)};
        q_va = {tab[2].vppn, 13'($urandom)};
        modes = '{mmu_pkg::INV_ALL0, mmu_pkg::INV_ALL1, mmu_pkg::INV_G1, mmu_pkg::INV_G0,
                  mmu_pkg::INV_G0_ASID, mmu_pkg::INV_G0_ASID_VA, mmu_pkg::INV_G1_ASID_VA};
        keep = '{5'b00000, 5'b00000, 5'b01011, 5'b10100, 5'b10110, 5'b11110, 5'b11011};
        for (int m = 0; m < 7; m++) begin
            invalidate(mmu_pkg::INV_ALL0, '0);
            for (int k = 0; k < 5; k++)
                write_entry(4'(k), tab[k]);
            invalidate(modes[m], (m == 6) ? q_va : p_va);
            for (int k = 0; k < 5; k++) begin
                read_entry(4'(k));
                check_flag(rd_entry.e, keep[m][k],
                           $sformatf("%s entry %0d", modes[m].name(), k));
            end
        end
    endtask

    initial begin
        errors = 0;
        timeouts = 0;
        clk = 1'b0;
        reset = 1'b1;
        fetch_va = '0;
        data_va = '0;
        data_store = 1'b0;
        cur_plv = 2'd0;
        cur_asid = 10'($urandom(32'h02909f80));
        op_valid = 1'b0;
        op = mmu_pkg::OP_SRCH;
        op_index = '0;
        op_entry = '0;
        inv_op = mmu_pkg::INV_ALL0;
        op_va = '0;
        repeat (2) @(posedge clk);
        #2;
        reset = 1'b0;

        test_reset_state();
        test_write_read();
        test_translate();
        test_exceptions();
        test_search();
        test_fill();
        test_invalidate();

        $display("errors: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0)
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    end

endmodule
